// ==== Makefile ====
# Verilator flow for the address lookup table

VERILATOR  ?= verilator
TOP        ?= tb_alut
RTL_TOP    ?= alut_top
FILELIST   ?= alut.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= *** PASSED ***
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0 -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) alut_config.svh $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# status comes from the search for the pass line
sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== alut.f ====
+incdir+.
alut_pkg.sv
alut_hash_stage.sv
alut_mem.sv
alut_match_stage.sv
alut_age_checker.sv
alut_top.sv
tb_alut.sv

// ==== alut_age_checker.sv ====
`timescale 1ns/1ps
`include "alut_config.svh"

module alut_age_checker
(
   input  logic                  pclk24,
   input  logic                  rst_n,
   input  alut_pkg::stamp_t      age_limit,    // max age in ticks
   input  logic                  a_acc_valid,  // add path access, watched
   input  alut_pkg::mem_acc_t    a_acc,
   output logic                  b_valid,      // memory port b
   output alut_pkg::mem_acc_t    b_acc,
   input  alut_pkg::alut_entry_t b_rdata,
   output alut_pkg::stamp_t      now           // current timestamp
);

   import alut_pkg::*;

   localparam int PRE_W = $clog2(`ALUT_AGE_PRESCALE);

   logic [PRE_W-1:0] pre_cnt;    // clocks within one tick
   age_state_t       state;
   idx_t             sweep_idx;  // entry under inspection
   logic             stale;      // judged too old
   logic             fresh;      // add path wrote sweep_idx since our read
   logic             add_hit;    // add path writes sweep_idx this cycle
   stamp_t           elapsed;    // ticks since the entry was learned

   // -------------------------------------------------------------------------
   // prescaler and timestamp
   // -------------------------------------------------------------------------
   always_ff @(posedge pclk24)
   begin
      if (!rst_n)
      begin
         pre_cnt <= '0;
         now     <= '0;
      end
      else if (pre_cnt == PRE_W'(`ALUT_AGE_PRESCALE - 1))
      begin
         pre_cnt <= '0;
         now     <= now + 1'b1;   // wraps, compare below is modulo
      end
      else
         pre_cnt <= pre_cnt + 1'b1;
   end

   // -------------------------------------------------------------------------
   // sweep FSM, 3 cycles per index
   // -------------------------------------------------------------------------
   assign add_hit = a_acc_valid && a_acc.write && (a_acc.idx == sweep_idx);
   assign elapsed = now - b_rdata.age;   // wrap-safe difference

   always_ff @(posedge pclk24)
   begin
      if (!rst_n)
      begin
         state     <= age_read;
         sweep_idx <= '0;
         stale     <= 1'b0;
         fresh     <= 1'b0;
      end
      else
      begin
         case (state)
            age_read:
            begin
               state <= age_judge;
               fresh <= add_hit;   // same-edge write, our read sees old data
            end
            age_judge:
            begin
               state <= age_write;
               stale <= b_rdata.valid && (elapsed > age_limit);
               fresh <= fresh || add_hit;
            end
            age_write:
            begin
               state <= age_read;
               stale <= 1'b0;
               fresh <= 1'b0;
               if (sweep_idx == idx_t'(`ALUT_DEPTH - 1))   // next pass
                  sweep_idx <= '0;
               else
                  sweep_idx <= sweep_idx + 1'b1;
            end
            default:
               state <= age_read;
         endcase
      end
   end

   // -------------------------------------------------------------------------
   // port b drive
   // -------------------------------------------------------------------------
   always_comb
   begin
      b_valid     = 1'b0;
      b_acc.write = 1'b0;
      b_acc.idx   = sweep_idx;
      b_acc.entry = '0;   // all-zero entry is invalid
      case (state)
         age_read:
            b_valid = 1'b1;
         age_write:
         begin
            // a learn on this slot wins over the invalidation
            b_valid     = stale && !fresh && !add_hit;
            b_acc.write = 1'b1;
         end
         default:
            b_valid = 1'b0;   // judge cycle, port idle
      endcase
   end

endmodule

// ==== alut_config.svh ====
`ifndef ALUT_CONFIG_SVH
`define ALUT_CONFIG_SVH

// ---------------------------------------------------------------------------
// table geometry
// ---------------------------------------------------------------------------
`define ALUT_DEPTH        256   // entries in the lookup table
`define ALUT_IDX_W        8     // bits of a table index, log2 of depth

// entry fields
`define ALUT_PORT_W       4     // switch port number
`define ALUT_AGE_W        30    // timestamp width, wraps

// ---------------------------------------------------------------------------
// aging
// ---------------------------------------------------------------------------
`define ALUT_AGE_PRESCALE 16    // clocks per timestamp tick

// read, judge and write/skip per index
`define ALUT_SWEEP_LEN    (3 * `ALUT_DEPTH)   // clocks per full table sweep

`endif

// ==== alut_hash_stage.sv ====
`timescale 1ns/1ps

module alut_hash_stage
(
   input  logic               pclk24,
   input  logic               rst_n,
   input  logic               req_valid,   // one-cycle request strobe
   input  alut_pkg::alut_req_t req,
   input  alut_pkg::stamp_t   now,         // from the age checker
   output logic               acc_valid,   // to memory port a
   output alut_pkg::mem_acc_t acc,
   output logic               pend_valid,  // lookup in flight
   output alut_pkg::mac_t     pend_mac
);

   import alut_pkg::*;

   logic        is_learn;   // decoded op
   idx_t        hash_idx;   // folded mac
   alut_entry_t new_entry;  // what a learn stores

   // -------------------------------------------------------------------------
   // combinational decode of the incoming request
   // -------------------------------------------------------------------------
   assign is_learn = (req.op == op_learn);
   assign hash_idx = mac_hash(req.mac);

   always_comb
   begin
      new_entry.valid = 1'b1;
      new_entry.age   = now;       // stamp at learn time
      new_entry.port  = req.port;
      new_entry.mac   = req.mac;
   end

   // -------------------------------------------------------------------------
   // stage register, control
   // -------------------------------------------------------------------------
   always_ff @(posedge pclk24)
   begin
      if (!rst_n)
      begin
         acc_valid  <= 1'b0;
         pend_valid <= 1'b0;
      end
      else
      begin
         acc_valid  <= req_valid;               // learn and lookup both hit memory
         pend_valid <= req_valid && !is_learn;  // only lookups give a result
      end
   end

   // payload, qualified by the valids above
   always_ff @(posedge pclk24)
   begin
      acc.write <= is_learn;   // lookup is a plain read
      acc.idx   <= hash_idx;
      acc.entry <= new_entry;  // ignored by memory on read
      pend_mac  <= req.mac;
   end

endmodule

// ==== alut_match_stage.sv ====
`timescale 1ns/1ps

module alut_match_stage
(
   input  logic                  pclk24,
   input  logic                  rst_n,
   input  logic                  pend_valid,  // lookup left the hash stage
   input  alut_pkg::mac_t        pend_mac,
   input  alut_pkg::alut_entry_t rdata,       // port a read data
   output logic                  res_valid,   // one-cycle result pulse
   output alut_pkg::alut_res_t   res
);

   import alut_pkg::*;

   logic  pend_q;    // aligned with rdata
   mac_t  mac_q;     // looked-up mac, aligned
   logic  hit;
   port_t hit_port;

   // -------------------------------------------------------------------------
   // align the pending lookup with the memory read data
   // -------------------------------------------------------------------------
   always_ff @(posedge pclk24)
   begin
      if (!rst_n)
         pend_q <= 1'b0;
      else
         pend_q <= pend_valid;
   end

   always_ff @(posedge pclk24)
   begin
      mac_q <= pend_mac;   // payload follows pend_q
   end

   // -------------------------------------------------------------------------
   // compare
   // -------------------------------------------------------------------------
   // a slot holding another mac with the same hash is a miss
   assign hit      = rdata.valid && (rdata.mac == mac_q);
   assign hit_port = hit ? rdata.port : '0;   // zero port on miss

   // -------------------------------------------------------------------------
   // result register
   // -------------------------------------------------------------------------
   always_ff @(posedge pclk24)
   begin
      if (!rst_n)
         res_valid <= 1'b0;
      else
         res_valid <= pend_q;
   end

   always_ff @(posedge pclk24)
   begin
      res.hit  <= hit;
      res.port <= hit_port;
      res.mac  <= mac_q;   // echo for the requester
   end

endmodule

// ==== alut_mem.sv ====
`timescale 1ns/1ps
`include "alut_config.svh"

module alut_mem
(
   input  logic                  pclk24,
   input  logic                  a_valid,   // add path access
   input  alut_pkg::mem_acc_t    a_acc,
   output alut_pkg::alut_entry_t a_rdata,
   input  logic                  b_valid,   // age path access
   input  alut_pkg::mem_acc_t    b_acc,
   output alut_pkg::alut_entry_t b_rdata
);

   import alut_pkg::*;

   // table contents are not reset
   alut_entry_t mem_core [`ALUT_DEPTH];

   // -------------------------------------------------------------------------
   // port a, read or write for the address lookup path
   // -------------------------------------------------------------------------
   always @(posedge pclk24)
   begin
      if (a_valid)
      begin
         if (!a_acc.write)   // read array
            a_rdata <= mem_core[a_acc.idx];
         else
            mem_core[a_acc.idx] <= a_acc.entry;
      end
   end

   // -------------------------------------------------------------------------
   // port b, read or write for the age checker
   // -------------------------------------------------------------------------
   always @(posedge pclk24)
   begin
      if (b_valid)
      begin
         if (!b_acc.write)   // read array
            b_rdata <= mem_core[b_acc.idx];
         else
            mem_core[b_acc.idx] <= b_acc.entry;   // invalidation
      end
   end

   // same-index write on both ports never happens,
   // the age checker drops its write in that case
   // read during write on the other port returns the old entry

endmodule

// ==== alut_pkg.sv ====
`include "alut_config.svh"

package alut_pkg;

   // -------------------------------------------------------------------------
   // plain widths
   // -------------------------------------------------------------------------
   typedef logic [47:0]              mac_t;     // ethernet address
   typedef logic [`ALUT_IDX_W-1:0]   idx_t;     // table index
   typedef logic [`ALUT_PORT_W-1:0]  port_t;    // ingress port
   typedef logic [`ALUT_AGE_W-1:0]   stamp_t;   // timestamp, modulo

   // one table entry, 1 + 30 + 4 + 48 = 83 bits
   typedef struct packed {
      logic   valid;    // slot holds a learned mac
      stamp_t age;      // stamp at learn time
      port_t  port;
      mac_t   mac;
   } alut_entry_t;

   typedef enum logic {
      op_lookup,
      op_learn
   } alut_op_t;

   // request from the port controller
   typedef struct packed {
      alut_op_t op;
      mac_t     mac;      // src mac on learn, dst mac on lookup
      port_t    port;     // only used by learn
   } alut_req_t;

   // one access on a memory port
   typedef struct packed {
      logic        write;   // 1 write, 0 read
      idx_t        idx;
      alut_entry_t entry;   // write data
   } mem_acc_t;

   typedef struct packed {
      logic  hit;
      port_t port;    // zero on miss
      mac_t  mac;     // the mac that was looked up
   } alut_res_t;

   typedef enum logic [1:0] {
      age_read,
      age_judge,
      age_write
   } age_state_t;

   // fold the six mac bytes into one index
   function automatic idx_t mac_hash(input mac_t mac);
      logic [7:0] h;
      h = '0;
      for (int i = 0; i < 6; i++)
         h = h ^ mac[i*8 +: 8];
      return idx_t'(h);
   endfunction

endpackage

// ==== alut_top.sv ====
`timescale 1ns/1ps

module alut_top
(
   input  logic                pclk24,
   input  logic                rst_n,
   input  logic                req_valid,  // learn or lookup strobe
   input  alut_pkg::alut_req_t req,
   input  alut_pkg::stamp_t    age_limit,
   output logic                res_valid,  // lookup result, 3 clocks after request
   output alut_pkg::alut_res_t res
);

   import alut_pkg::*;

   // -------------------------------------------------------------------------
   // add path
   // -------------------------------------------------------------------------
   logic        acc_valid;
   mem_acc_t    acc;
   logic        pend_valid;   // lookup side channel
   mac_t        pend_mac;
   alut_entry_t a_rdata;

   // age path
   logic        b_valid;
   mem_acc_t    b_acc;
   alut_entry_t b_rdata;
   stamp_t      now;          // learn timestamp

   alut_hash_stage u_hash (
      .pclk24     (pclk24),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .now        (now),
      .acc_valid  (acc_valid),
      .acc        (acc),
      .pend_valid (pend_valid),
      .pend_mac   (pend_mac)
   );

   alut_mem u_mem (
      .pclk24  (pclk24),
      .a_valid (acc_valid),
      .a_acc   (acc),
      .a_rdata (a_rdata),
      .b_valid (b_valid),
      .b_acc   (b_acc),
      .b_rdata (b_rdata)
   );

   // sees the add path to drop colliding invalidations
   alut_age_checker u_age (
      .pclk24      (pclk24),
      .rst_n       (rst_n),
      .age_limit   (age_limit),
      .a_acc_valid (acc_valid),
      .a_acc       (acc),
      .b_valid     (b_valid),
      .b_acc       (b_acc),
      .b_rdata     (b_rdata),
      .now         (now)
   );

   alut_match_stage u_match (
      .pclk24     (pclk24),
      .rst_n      (rst_n),
      .pend_valid (pend_valid),
      .pend_mac   (pend_mac),
      .rdata      (a_rdata),
      .res_valid  (res_valid),
      .res        (res)
   );

endmodule

// ==== tb_alut.sv ====
`timescale 1ns/1ps
`include "alut_config.svh"

module tb_alut;

   import alut_pkg::*;

   localparam int TICK        = `ALUT_AGE_PRESCALE;   // clocks per stamp tick
   localparam int SWEEP       = `ALUT_SWEEP_LEN;      // clocks per table pass
   localparam int N_LEARN     = 40;
   localparam int N_MIX       = 200;
   localparam int N_AGE       = 16;
   localparam int N_COLL      = 8;                    // learns aimed at a sweep write
   localparam int AGE_SMALL   = 4;                    // ticks
   // past this many clocks since its learn an entry must be gone
   localparam int STALE_BOUND = (AGE_SMALL + 1) * TICK + 2 * SWEEP;
   localparam int PLAN_CYCLES = 16 + 2 * N_LEARN + 40 + 2 * N_MIX + 3 * N_AGE
                                + STALE_BOUND + 80 + `ALUT_DEPTH
                                + (AGE_SMALL + 2) * TICK + N_COLL * 32;
   localparam int MARGIN      = 500;

   logic      pclk24;
   logic      rst_n;
   logic      req_valid;
   alut_req_t req;
   stamp_t    age_limit;
   logic      res_valid;
   alut_res_t res;

   int cyc = 0;   // rising edges seen

   // reference table indexed by the folded mac
   logic  ref_valid [`ALUT_DEPTH];
   mac_t  ref_mac   [`ALUT_DEPTH];
   port_t ref_port  [`ALUT_DEPTH];
   int    ref_cyc   [`ALUT_DEPTH];   // learn cycle
   logic  aging_on  = 1'b0;          // small age_limit in force
   int    limit_cyc = 0;

   alut_res_t exp_q [$];      // expected results in request order
   int        iss_q [$];      // issue cycle of each lookup
   mac_t      learned_q [$];
   mac_t      aged_q [$];

   int n_checks     = 0;
   int value_errs   = 0;
   int latency_errs = 0;
   int other_errs   = 0;

   alut_top dut (
      .pclk24    (pclk24),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .age_limit (age_limit),
      .res_valid (res_valid),
      .res       (res)
   );

   initial pclk24 = 1'b0;
   always #10 pclk24 = ~pclk24;   // 50 MHz

   always @(posedge pclk24)
      cyc <= cyc + 1;

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------
   function automatic idx_t fold_mac(input mac_t m);
      idx_t h;
      h = '0;
      for (int i = 0; i < 6; i++)
         h = h ^ m[i*8 +: 8];   // byte-wise xor
      return h;
   endfunction

   function automatic mac_t random_mac();
      return {16'($urandom), $urandom};
   endfunction

   // random mac with the low byte bent so it folds onto target
   function automatic mac_t mac_for_idx(input idx_t target);
      mac_t m;
      m      = random_mac();
      m[7:0] = m[7:0] ^ fold_mac(m) ^ target;
      return m;
   endfunction

   function automatic alut_res_t expect_lookup(input mac_t m, input int t);
      alut_res_t r;
      idx_t      i;
      logic      aged;
      i      = fold_mac(m);
      aged   = aging_on && (t - ref_cyc[i] > STALE_BOUND) && (t - limit_cyc > 2 * SWEEP);
      r.hit  = ref_valid[i] && (ref_mac[i] == m) && !aged;
      r.port = r.hit ? ref_port[i] : '0;
      r.mac  = m;
      return r;
   endfunction

   // ------------------------------------------------------------------------
   // stimulus driven 1 ns after the rising edge
   // ------------------------------------------------------------------------
   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge pclk24);
         #1;
         req_valid = 1'b0;
      end
   endtask

   task automatic issue_learn(input mac_t m, input port_t p);
      idx_t i;
      @(posedge pclk24);
      #1;
      req_valid = 1'b1;
      req.op    = op_learn;
      req.mac   = m;
      req.port  = p;
      i = fold_mac(m);   // collisions replace the old entry
      ref_valid[i] = 1'b1;
      ref_mac[i]   = m;
      ref_port[i]  = p;
      ref_cyc[i]   = cyc;
   endtask

   task automatic issue_lookup(input mac_t m);
      @(posedge pclk24);
      #1;
      req_valid = 1'b1;
      req.op    = op_lookup;
      req.mac   = m;
      req.port  = '0;
      exp_q.push_back(expect_lookup(m, cyc));   // model as of issue
      iss_q.push_back(cyc);
   endtask

   task automatic flag_mismatch(input string sig, input logic [47:0] expv,
                                input logic [47:0] gotv);
      value_errs++;
      $display("error at %0t: %s expected %0h got %0h", $time, sig, expv, gotv);
   endtask

   // ------------------------------------------------------------------------
   // comparator sampling on the falling edge
   // ------------------------------------------------------------------------
   always @(negedge pclk24)
   begin : compare
      alut_res_t e;
      int        t0;
      if (rst_n && res_valid)
      begin
         if (exp_q.size() == 0)
         begin
            other_errs++;
            $display("result at %0t arrived with no lookup outstanding", $time);
         end
         else
         begin
            e  = exp_q.pop_front();
            t0 = iss_q.pop_front();
            n_checks++;
            if (res.hit !== e.hit)
               flag_mismatch("res.hit", 48'(e.hit), 48'(res.hit));
            if (res.port !== e.port)
               flag_mismatch("res.port", 48'(e.port), 48'(res.port));
            if (res.mac !== e.mac)
               flag_mismatch("res.mac", e.mac, res.mac);
            if (cyc - t0 != 3)
            begin
               latency_errs++;
               $display("lookup issued in cycle %0d answered after %0d cycles, not 3",
                        t0, cyc - t0);
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------
   task automatic learn_then_lookup();
      mac_t m;
      for (int i = 0; i < N_LEARN; i++)
      begin
         m = random_mac();
         issue_learn(m, port_t'($urandom));
         learned_q.push_back(m);
      end
      idle_cycles(2);
      foreach (learned_q[i])
         issue_lookup(learned_q[i]);
      idle_cycles(4);
   endtask

   task automatic miss_and_collision();
      mac_t       a;
      mac_t       b;
      logic [7:0] k;
      a = random_mac();
      k = 8'($urandom_range(255, 1));
      b = a ^ {32'h0, k, k};   // other mac with the same fold
      issue_learn(a, port_t'(3));
      idle_cycles(1);
      issue_lookup(b);           // slot holds a
      issue_lookup(a);
      issue_learn(b, port_t'(9));
      issue_lookup(a);           // replaced by b
      issue_lookup(b);
      idle_cycles(4);
      learned_q.push_back(b);
   endtask

   task automatic back_to_back();
      mac_t m;
      int   sel;
      for (int i = 0; i < N_MIX; i++)
      begin
         sel = int'($urandom_range(2));
         m   = learned_q[$urandom_range(learned_q.size() - 1)];
         if (sel == 0)
         begin
            m = random_mac();
            issue_learn(m, port_t'($urandom));
            learned_q.push_back(m);
         end
         else if (sel == 1)
         begin
            issue_learn(m, port_t'($urandom));   // lookup follows next cycle
            issue_lookup(m);
         end
         else
            issue_lookup(m);
      end
      idle_cycles(4);
   endtask

   task automatic stale_entries_age_out();
      mac_t m;
      for (int i = 0; i < N_AGE; i++)
      begin
         m = random_mac();
         issue_learn(m, port_t'($urandom));
         aged_q.push_back(m);
      end
      foreach (aged_q[i])
         issue_lookup(aged_q[i]);
      idle_cycles(1);
      age_limit = stamp_t'(AGE_SMALL);
      aging_on  = 1'b1;
      limit_cyc = cyc;
      idle_cycles(STALE_BOUND + 32);   // limit+1 ticks and two sweeps
      foreach (aged_q[i])
         issue_lookup(aged_q[i]);
      for (int i = 0; i < 8; i++)
         issue_lookup(learned_q[i]);
      idle_cycles(4);
   endtask

   task automatic fresh_entries_survive();
      mac_t m;
      idx_t s;
      mac_t young_q [$];
      // slots just ahead of the sweep, judged while still young
      s = dut.u_age.sweep_idx;
      for (int i = 0; i < 4; i++)
      begin
         m = mac_for_idx(idx_t'(s + 2 + i));
         issue_learn(m, port_t'($urandom));
         young_q.push_back(m);
      end
      idle_cycles(2 * TICK - 4);   // about two ticks old at lookup
      foreach (young_q[i])
         issue_lookup(young_q[i]);
      // fill every slot and let it go stale ahead of the sweep
      for (int i = 0; i < `ALUT_DEPTH; i++)
         issue_learn(mac_for_idx(idx_t'(i)), port_t'($urandom));
      idle_cycles((AGE_SMALL + 2) * TICK);
      for (int k = 0; k < N_COLL; k++)
      begin
         while (dut.u_age.state != age_read)
            idle_cycles(1);
         s = dut.u_age.sweep_idx;
         m = mac_for_idx(s);
         issue_learn(m, port_t'(k));   // reaches port a in the write cycle
         issue_lookup(m);
         idle_cycles(20);
         issue_lookup(m);              // invalidation must have been dropped
         idle_cycles(3);
      end
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      void'($urandom(32'hc813_b94a));
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      age_limit = '1;   // nothing ages yet
      for (int i = 0; i < `ALUT_DEPTH; i++)
         ref_valid[i] = 1'b0;
      repeat (16) @(posedge pclk24);
      #1;
      rst_n = 1'b1;

      learn_then_lookup();
      miss_and_collision();
      back_to_back();
      stale_entries_age_out();
      fresh_entries_survive();
      idle_cycles(8);

      if (exp_q.size() != 0)
      begin
         other_errs++;
         $display("%0d lookups never produced a result", exp_q.size());
      end
      $display("checks %0d, value errors %0d, latency errors %0d, other errors %0d",
               n_checks, value_errs, latency_errs, other_errs);
      if (value_errs + latency_errs + other_errs == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // watchdog
   initial
   begin
      #(20 * (PLAN_CYCLES + MARGIN));
      $display("watchdog expired in cycle %0d, the tests did not finish", cyc);
      $display("*** FAILED ***");
      $finish;
   end

endmodule
